//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and storage sizes
`define NB_WORD        32
`define NB_REG_ADDR    5
`define REGFILE_DEPTH  32
`define NB_INSTR_ADDR  10
`define INSTR_DEPTH    1024

// Host frame holds cmd in 31:26, addr in 25:16 and data in 15:0
`define NB_HALF        16
`define NB_CMD         6
`define FRAME_CMD_MSB  31
`define FRAME_ADDR_MSB 25
`define NB_FRAME_ADDR  10

// Opcode that stops the pipeline
`define HALT_OPCODE    6'b111111

`endif

//--- isa_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package isa_pkg;

   typedef logic [`NB_WORD-1:0]       word_t;
   typedef logic [`NB_REG_ADDR-1:0]   reg_addr_t;
   typedef logic [`NB_INSTR_ADDR-1:0] instr_addr_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDIU = 6'h09,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f,
      OP_HALT  = `HALT_OPCODE
   } opcode_t;

   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI, ALU_PASS
   } alu_op_t;

endpackage

`default_nettype wire

//--- host_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package host_pkg;

   typedef logic [`FRAME_CMD_MSB:0] frame_t;

   typedef enum logic [`NB_CMD-1:0] {
      CMD_INSTR_LOW  = 6'h01,
      CMD_INSTR_HIGH = 6'h02,
      CMD_RUN        = 6'h03,
      CMD_READ_REG   = 6'h04
   } host_cmd_t;

   typedef enum logic [1:0] {
      IDLE,
      RUNNING,
      HALTED
   } host_state_t;

endpackage

`default_nettype wire

//--- instruction_fetch.sv
`default_nettype none

`include "cpu_defines.svh"

module instruction_fetch
   import isa_pkg::*;
   (
   input  wire         i_clock,
   input  wire         reset,
   input  wire         i_start,
   input  wire         i_stall,
   input  wire         i_imem_we,
   input  instr_addr_t i_imem_addr,
   input  word_t       i_imem_data,
   output word_t       o_instr,
   output logic        o_instr_valid
   );

   word_t       imem [`INSTR_DEPTH];
   instr_addr_t pc;
   logic        active;

   // Host write port
   always_ff @(posedge i_clock) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         pc            <= '0;
         active        <= 1'b0;
         o_instr_valid <= 1'b0;
      end else if (i_start) begin
         pc            <= '0;
         active        <= 1'b1;
         o_instr_valid <= 1'b0;
      end else if (active && !i_stall) begin
         pc            <= pc + instr_addr_t'(1);
         o_instr_valid <= 1'b1;
      end else begin
         // PC frozen, nothing new handed to decode
         o_instr_valid <= 1'b0;
      end
   end

   always_ff @(posedge i_clock) begin
      if (active && !i_stall) begin
         o_instr <= imem[pc];
      end
   end

endmodule

`default_nettype wire

//--- instruction_decode.sv
`default_nettype none

`include "cpu_defines.svh"

module instruction_decode
   import isa_pkg::*;
   (
   input  wire                     i_clock,
   input  wire                     reset,
   input  wire                     i_start,
   input  word_t                   i_instr,
   input  wire                     i_instr_valid,
   input  word_t                   i_ex_result,
   input  reg_addr_t               i_ex_dest,
   input  wire                     i_ex_we,
   input  wire                     i_wb_we,
   input  reg_addr_t               i_wb_dest,
   input  word_t                   i_wb_data,
   input  reg_addr_t               i_read_addr,
   output word_t                   o_read_data,
   output word_t                   o_a,
   output word_t                   o_b,
   output word_t                   o_imm,
   output logic [`NB_REG_ADDR-1:0] o_shamt,
   output logic                    o_use_imm,
   output alu_op_t                 o_alu_op,
   output reg_addr_t               o_dest,
   output logic                    o_we,
   output logic                    o_halt,
   output logic                    o_valid,
   output logic                    o_stall
   );

   word_t     regs [`REGFILE_DEPTH];
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   word_t     rf_a;
   word_t     rf_b;
   word_t     fwd_a;
   word_t     fwd_b;
   word_t     imm_ext;
   reg_addr_t dest;
   alu_op_t   alu_op;
   logic      use_imm;
   logic      we;
   logic      is_halt;
   logic      halt_seen;
   logic      accept;

   // Register 0 reads zero, same-cycle writeback is seen
   function automatic word_t rf_read(input reg_addr_t addr);
      word_t value;
      if (addr == '0) begin
         value = '0;
      end else if (i_wb_we && i_wb_dest == addr) begin
         value = i_wb_data;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   assign rs = i_instr[25:21];
   assign rt = i_instr[20:16];
   assign rd = i_instr[15:11];

   always_ff @(posedge i_clock) begin
      if (i_wb_we && i_wb_dest != '0) begin
         regs[i_wb_dest] <= i_wb_data;
      end
   end

   always_comb begin
      rf_a        = rf_read(rs);
      rf_b        = rf_read(rt);
      o_read_data = rf_read(i_read_addr);
   end

   // Result of the instruction now in execute
   assign fwd_a = (i_ex_we && i_ex_dest != '0 && i_ex_dest == rs) ? i_ex_result : rf_a;
   assign fwd_b = (i_ex_we && i_ex_dest != '0 && i_ex_dest == rt) ? i_ex_result : rf_b;

   always_comb begin
      alu_op  = ALU_PASS;
      use_imm = 1'b0;
      we      = 1'b0;
      is_halt = 1'b0;
      dest    = rd;
      imm_ext = {{`NB_HALF{1'b0}}, i_instr[`NB_HALF-1:0]};
      case (opcode_t'(i_instr[31:26]))
         OP_RTYPE: begin
            we = 1'b1;
            case (funct_t'(i_instr[5:0]))
               FN_ADDU: alu_op = ALU_ADDU;
               FN_SUBU: alu_op = ALU_SUBU;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               default: we = 1'b0;
            endcase
         end
         OP_ADDIU: begin
            alu_op  = ALU_ADDU;
            imm_ext = {{`NB_HALF{i_instr[`NB_HALF-1]}}, i_instr[`NB_HALF-1:0]};
         end
         OP_ANDI: alu_op = ALU_AND;
         OP_ORI:  alu_op = ALU_OR;
         OP_XORI: alu_op = ALU_XOR;
         OP_LUI:  alu_op = ALU_LUI;
         OP_HALT: is_halt = 1'b1;
         default: alu_op = ALU_PASS;
      endcase
      // All immediate forms write rt
      if (opcode_t'(i_instr[31:26]) inside {OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
         use_imm = 1'b1;
         we      = 1'b1;
         dest    = rt;
      end
   end

   assign accept  = i_instr_valid && !halt_seen;
   assign o_stall = halt_seen || (i_instr_valid && is_halt);

   always_ff @(posedge i_clock) begin
      if (reset || i_start) begin
         o_valid   <= 1'b0;
         o_we      <= 1'b0;
         o_halt    <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         o_valid   <= accept;
         o_we      <= accept && we;
         o_halt    <= accept && is_halt;
         halt_seen <= halt_seen || (accept && is_halt);
      end
   end

   always_ff @(posedge i_clock) begin
      o_a       <= fwd_a;
      o_b       <= fwd_b;
      o_imm     <= imm_ext;
      o_shamt   <= i_instr[10:6];
      o_use_imm <= use_imm;
      o_alu_op  <= alu_op;
      o_dest    <= dest;
   end

endmodule

`default_nettype wire

//--- execution.sv
`default_nettype none

`include "cpu_defines.svh"

module execution
   import isa_pkg::*;
   (
   input  wire                     i_clock,
   input  wire                     reset,
   input  wire                     i_start,
   input  word_t                   i_a,
   input  word_t                   i_b,
   input  word_t                   i_imm,
   input  wire [`NB_REG_ADDR-1:0]  i_shamt,
   input  wire                     i_use_imm,
   input  alu_op_t                 i_alu_op,
   input  reg_addr_t               i_dest,
   input  wire                     i_we,
   input  wire                     i_halt,
   input  wire                     i_valid,
   output word_t                   o_result,
   output reg_addr_t               o_dest,
   output logic                    o_we,
   output logic                    o_wb_we,
   output reg_addr_t               o_wb_dest,
   output word_t                   o_wb_data,
   output logic                    o_halt_done
   );

   word_t op_b;

   assign op_b = i_use_imm ? i_imm : i_b;

   always_comb begin
      case (i_alu_op)
         ALU_ADDU: o_result = i_a + op_b;
         ALU_SUBU: o_result = i_a - op_b;
         ALU_AND:  o_result = i_a & op_b;
         ALU_OR:   o_result = i_a | op_b;
         ALU_XOR:  o_result = i_a ^ op_b;
         ALU_SLT:  o_result = {{(`NB_WORD-1){1'b0}}, $signed(i_a) < $signed(op_b)};
         // Shifts act on rt, as in MIPS
         ALU_SLL:  o_result = op_b << i_shamt;
         ALU_SRL:  o_result = op_b >> i_shamt;
         ALU_LUI:  o_result = {op_b[`NB_HALF-1:0], {`NB_HALF{1'b0}}};
         default:  o_result = op_b;
      endcase
   end

   // Forwarding view of the instruction in execute
   assign o_dest = i_dest;
   assign o_we   = i_we && i_valid;

   always_ff @(posedge i_clock) begin
      if (reset || i_start) begin
         o_wb_we     <= 1'b0;
         o_halt_done <= 1'b0;
      end else begin
         o_wb_we     <= i_we && i_valid;
         o_halt_done <= i_halt && i_valid;
      end
   end

   always_ff @(posedge i_clock) begin
      o_wb_dest <= i_dest;
      o_wb_data <= o_result;
   end

endmodule

`default_nettype wire

//--- host_interface.sv
`default_nettype none

`include "cpu_defines.svh"

module host_interface
   import isa_pkg::*, host_pkg::*;
   (
   input  wire         i_clock,
   input  wire         reset,
   input  wire         i_frame_valid,
   input  frame_t      i_frame_from_host,
   input  word_t       i_reg_read_data,
   input  wire         i_halt_done,
   output logic        o_imem_we,
   output instr_addr_t o_imem_addr,
   output word_t       o_imem_data,
   output logic        o_start,
   output reg_addr_t   o_reg_read_addr,
   output logic        o_frame_valid,
   output frame_t      o_frame_to_host,
   output logic        o_halted
   );

   host_cmd_t                  cmd;
   logic [`NB_FRAME_ADDR-1:0]  frame_addr;
   logic [`NB_HALF-1:0]        frame_data;
   logic [`NB_HALF-1:0]        low_half;
   host_state_t                state;
   logic                       read_pending;

   assign cmd        = host_cmd_t'(i_frame_from_host[`FRAME_CMD_MSB -: `NB_CMD]);
   assign frame_addr = i_frame_from_host[`FRAME_ADDR_MSB -: `NB_FRAME_ADDR];
   assign frame_data = i_frame_from_host[`NB_HALF-1:0];

   // Instruction word goes in with its high half
   assign o_imem_we   = i_frame_valid && cmd == CMD_INSTR_HIGH;
   assign o_imem_addr = frame_addr;
   assign o_imem_data = {frame_data, low_half};

   // RUN while running is dropped
   assign o_start  = i_frame_valid && cmd == CMD_RUN && state != RUNNING;
   assign o_halted = state == HALTED;

   always_ff @(posedge i_clock) begin
      if (i_frame_valid && cmd == CMD_INSTR_LOW) begin
         low_half <= frame_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:    if (o_start) state <= RUNNING;
            RUNNING: if (i_halt_done) state <= HALTED;
            HALTED:  if (o_start) state <= RUNNING;
            default: state <= IDLE;
         endcase
      end
   end

   // Read address latched first and the value one edge later
   always_ff @(posedge i_clock) begin
      if (reset) begin
         read_pending  <= 1'b0;
         o_frame_valid <= 1'b0;
      end else begin
         read_pending  <= i_frame_valid && cmd == CMD_READ_REG;
         o_frame_valid <= read_pending;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_frame_valid && cmd == CMD_READ_REG) begin
         o_reg_read_addr <= frame_addr[`NB_REG_ADDR-1:0];
      end
      if (read_pending) begin
         o_frame_to_host <= i_reg_read_data;
      end
   end

endmodule

`default_nettype wire

//--- pipeline.sv
`default_nettype none

`include "cpu_defines.svh"

module pipeline
   import isa_pkg::*, host_pkg::*;
   (
   input  wire    i_clock,
   input  wire    reset,
   input  wire    i_frame_valid,
   input  frame_t i_frame_from_host,
   output logic   o_frame_valid,
   output frame_t o_frame_to_host,
   output logic   o_halted
   );

   // Host side
   logic        host_imem_we;
   instr_addr_t host_imem_addr;
   word_t       host_imem_data;
   logic        host_start;
   reg_addr_t   host_read_addr;
   word_t       deco_read_data;

   // Fetch to decode
   word_t       if_instr_deco;
   logic        if_valid_deco;
   logic        deco_stall_if;

   // Decode to execute
   word_t                   deco_a_ex;
   word_t                   deco_b_ex;
   word_t                   deco_imm_ex;
   logic [`NB_REG_ADDR-1:0] deco_shamt_ex;
   logic                    deco_use_imm_ex;
   alu_op_t                 deco_alu_op_ex;
   reg_addr_t               deco_dest_ex;
   logic                    deco_we_ex;
   logic                    deco_halt_ex;
   logic                    deco_valid_ex;

   // Execute back to decode and host
   word_t       ex_result_fwd;
   reg_addr_t   ex_dest_fwd;
   logic        ex_we_fwd;
   logic        wb_we;
   reg_addr_t   wb_dest;
   word_t       wb_data;
   logic        ex_halt_done;

   host_interface u_host_interface (
      .i_clock           (i_clock),
      .reset             (reset),
      .i_frame_valid     (i_frame_valid),
      .i_frame_from_host (i_frame_from_host),
      .i_reg_read_data   (deco_read_data),
      .i_halt_done       (ex_halt_done),
      .o_imem_we         (host_imem_we),
      .o_imem_addr       (host_imem_addr),
      .o_imem_data       (host_imem_data),
      .o_start           (host_start),
      .o_reg_read_addr   (host_read_addr),
      .o_frame_valid     (o_frame_valid),
      .o_frame_to_host   (o_frame_to_host),
      .o_halted          (o_halted)
   );

   instruction_fetch u_instruction_fetch (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_start       (host_start),
      .i_stall       (deco_stall_if),
      .i_imem_we     (host_imem_we),
      .i_imem_addr   (host_imem_addr),
      .i_imem_data   (host_imem_data),
      .o_instr       (if_instr_deco),
      .o_instr_valid (if_valid_deco)
   );

   instruction_decode u_instruction_decode (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_start       (host_start),
      .i_instr       (if_instr_deco),
      .i_instr_valid (if_valid_deco),
      .i_ex_result   (ex_result_fwd),
      .i_ex_dest     (ex_dest_fwd),
      .i_ex_we       (ex_we_fwd),
      .i_wb_we       (wb_we),
      .i_wb_dest     (wb_dest),
      .i_wb_data     (wb_data),
      .i_read_addr   (host_read_addr),
      .o_read_data   (deco_read_data),
      .o_a           (deco_a_ex),
      .o_b           (deco_b_ex),
      .o_imm         (deco_imm_ex),
      .o_shamt       (deco_shamt_ex),
      .o_use_imm     (deco_use_imm_ex),
      .o_alu_op      (deco_alu_op_ex),
      .o_dest        (deco_dest_ex),
      .o_we          (deco_we_ex),
      .o_halt        (deco_halt_ex),
      .o_valid       (deco_valid_ex),
      .o_stall       (deco_stall_if)
   );

   execution u_execution (
      .i_clock     (i_clock),
      .reset       (reset),
      .i_start     (host_start),
      .i_a         (deco_a_ex),
      .i_b         (deco_b_ex),
      .i_imm       (deco_imm_ex),
      .i_shamt     (deco_shamt_ex),
      .i_use_imm   (deco_use_imm_ex),
      .i_alu_op    (deco_alu_op_ex),
      .i_dest      (deco_dest_ex),
      .i_we        (deco_we_ex),
      .i_halt      (deco_halt_ex),
      .i_valid     (deco_valid_ex),
      .o_result    (ex_result_fwd),
      .o_dest      (ex_dest_fwd),
      .o_we        (ex_we_fwd),
      .o_wb_we     (wb_we),
      .o_wb_dest   (wb_dest),
      .o_wb_data   (wb_data),
      .o_halt_done (ex_halt_done)
   );

endmodule

`default_nettype wire

//--- tb_pipeline.sv
`default_nettype none

module tb_pipeline
   import isa_pkg::*, host_pkg::*;
   ();

   typedef logic [8*24-1:0] name_t;

   logic   i_clock;
   logic   reset;
   logic   i_frame_valid;
   frame_t i_frame_from_host;
   logic   o_frame_valid;
   frame_t o_frame_to_host;
   logic   o_halted;

   // Test table filled from the vectors file
   name_t     test_names[$];
   int        word_first[$];
   int        word_count[$];
   int        check_first[$];
   int        check_count[$];
   word_t     words[$];
   reg_addr_t check_regs[$];
   word_t     check_values[$];

   logic [31:0] lfsr_state;
   int unsigned cycle_count = 0;
   int unsigned cycle_limit = 32'hffffffff;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   pipeline uut (
      .i_clock           (i_clock),
      .reset             (reset),
      .i_frame_valid     (i_frame_valid),
      .i_frame_from_host (i_frame_from_host),
      .o_frame_valid     (o_frame_valid),
      .o_frame_to_host   (o_frame_to_host),
      .o_halted          (o_halted)
   );

   initial begin
      i_clock = 1'b0;
      forever begin
         #20 i_clock = ~i_clock;
      end
   end

   always @(posedge i_clock) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      while (cycle_count < cycle_limit) begin
         @(posedge i_clock);
      end
      $display("Timeout after %0d clock cycles, the run did not finish", cycle_count);
      $display("Something failed");
      $finish;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic idle_gap();
      logic [1:0] gap;
      lfsr_state = lfsr_step(lfsr_state);
      gap[1] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      gap[0] = lfsr_state[0];
      repeat (gap) @(negedge i_clock);
   endtask

   task automatic load_vectors();
      int               fd;
      int               code;
      int               n;
      int               i;
      int               reg_num;
      int unsigned      total;
      logic [8*24-1:0]  token;
      logic [8*160-1:0] rest;
      word_t            word;
      logic             done;
      total = 0;
      fd = $fopen("pipeline_vectors.txt", "r");
      if (fd == 0) begin
         $display("The vectors file pipeline_vectors.txt could not be opened");
         errors++;
      end else begin
         done = 1'b0;
         while (!done) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
               done = 1'b1;
            end else if (token == "#") begin
               code = $fgets(rest, fd);
            end else begin
               test_names.push_back(token);
               code = $fscanf(fd, "%d", n);
               word_first.push_back(words.size());
               word_count.push_back(n);
               for (i = 0; i < n; i++) begin
                  code = $fscanf(fd, "%h", word);
                  words.push_back(word);
               end
               total += 3 * n + 21;
               code = $fscanf(fd, "%d", n);
               check_first.push_back(check_regs.size());
               check_count.push_back(n);
               for (i = 0; i < n; i++) begin
                  code = $fscanf(fd, "%d %h", reg_num, word);
                  check_regs.push_back(reg_addr_t'(reg_num));
                  check_values.push_back(word);
               end
               total += n;
            end
         end
         $fclose(fd);
      end
      // Four cycles per frame and instruction, plus slack per test
      cycle_limit = 4 * total;
   endtask

   task automatic send_frame(input host_cmd_t cmd, input instr_addr_t addr,
                             input logic [15:0] data);
      @(negedge i_clock);
      i_frame_from_host = {cmd, addr, data};
      i_frame_valid     = 1'b1;
      @(negedge i_clock);
      i_frame_valid     = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output word_t value, output logic got_reply);
      int waited;
      waited = 0;
      send_frame(CMD_READ_REG, instr_addr_t'(addr), 16'h0000);
      while (!o_frame_valid && waited < 4) begin
         @(negedge i_clock);
         waited++;
      end
      got_reply = o_frame_valid;
      value     = o_frame_to_host;
   endtask

   task automatic finish_test(input name_t name, input int test_errors, input int checks);
      if (test_errors == 0) begin
         tests_passed++;
         $display("Test %0s passed, %0d checks", name, checks);
      end else begin
         tests_failed++;
         errors += test_errors;
         $display("Test %0s failed with %0d errors", name, test_errors);
      end
   endtask

   task automatic check_reset_and_readback();
      int test_errors;
      test_errors = 0;
      assert (o_halted == 1'b0) else begin
         $display("o_halted is high after reset");
         test_errors++;
      end
      assert (o_frame_valid == 1'b0) else begin
         $display("o_frame_valid is high after reset");
         test_errors++;
      end
      send_frame(CMD_READ_REG, 10'd0, 16'h0000);
      assert (o_frame_valid == 1'b0) else begin
         $display("Reply frame came in the same cycle as the read");
         test_errors++;
      end
      @(negedge i_clock);
      assert (o_frame_valid == 1'b1) else begin
         $display("No reply frame one cycle after the read");
         test_errors++;
      end
      assert (o_frame_to_host == '0) else begin
         $display("Error test reset_readback register 0 expected %h actual %h",
                  32'h0, o_frame_to_host);
         test_errors++;
      end
      @(negedge i_clock);
      assert (o_frame_valid == 1'b0) else begin
         $display("Reply frame stayed valid for more than one cycle");
         test_errors++;
      end
      finish_test("reset_readback", test_errors, 5);
   endtask

   task automatic run_test(input int t);
      int    test_errors;
      int    i;
      int    c;
      word_t word;
      word_t actual;
      logic  got;
      test_errors = 0;
      for (i = 0; i < word_count[t]; i++) begin
         word = words[word_first[t] + i];
         idle_gap();
         send_frame(CMD_INSTR_LOW, instr_addr_t'(i), word[15:0]);
         idle_gap();
         send_frame(CMD_INSTR_HIGH, instr_addr_t'(i), word[31:16]);
      end
      idle_gap();
      send_frame(CMD_RUN, 10'd0, 16'h0000);
      assert (o_halted == 1'b0) else begin
         $display("o_halted still high after RUN in test %0s", test_names[t]);
         test_errors++;
      end
      // Run length depends on the program
      while (!o_halted) begin
         @(negedge i_clock);
      end
      for (c = check_first[t]; c < check_first[t] + check_count[t]; c++) begin
         idle_gap();
         read_reg(check_regs[c], actual, got);
         assert (got) else begin
            $display("No reply frame for register %0d in test %0s", check_regs[c],
                     test_names[t]);
            test_errors++;
         end
         if (got) begin
            assert (actual == check_values[c]) else begin
               $display("Error test %0s register %0d expected %h actual %h", test_names[t],
                        check_regs[c], check_values[c], actual);
               test_errors++;
            end
         end
      end
      finish_test(test_names[t], test_errors, check_count[t]);
   endtask

   initial begin
      int t;
      reset             = 1'b1;
      i_frame_valid     = 1'b0;
      i_frame_from_host = '0;
      lfsr_state        = 32'h3bc3;
      load_vectors();
      repeat (8) @(negedge i_clock);
      reset = 1'b0;
      check_reset_and_readback();
      for (t = 0; t < test_names.size(); t++) begin
         run_test(t);
      end
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && test_names.size() > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- pipeline_vectors.txt
# Per test: name, instruction count, instruction words (hex),
# then check count and pairs of register (decimal) and expected value (hex)
alu_basic 14
24010007 2402fffd 34038001 3c041234 00000000 00000000 00222821
00223023 0041382a 00034100 00044a02 304aff0f 382bffff fc000000
11 1 00000007 2 fffffffd 3 00008001 4 12340000 5 00000004 6 0000000a
7 00000001 8 00080010 9 00123400 10 0000ff0d 11 0000fff8
forwarding 10
24010005 00211021 00411821 00622026 00822825 00a33024 24210001 24210001
00263823 fc000000
7 1 00000007 2 0000000a 3 0000000f 4 00000005 5 0000000f 6 0000000f 7 fffffff8
reg_zero 6
24000055 00000821 34021234 3c00ffff 00401821 fc000000
4 0 00000000 1 00000000 2 00001234 3 00001234
halt_stops 7
24080011 24090022 240a0033 fc000000 24080099 240900aa 240a00bb
3 8 00000011 9 00000022 10 00000033
second_program 6
3c0cabcd 358c1357 000c6c02 01ac702a 018d782a fc000000
4 12 abcd1357 13 0000abcd 14 00000000 15 00000001

//--- all.f
+incdir+.
isa_pkg.sv
host_pkg.sv
instruction_fetch.sv
instruction_decode.sv
execution.sv
host_interface.sv
pipeline.sv
tb_pipeline.sv

//--- Makefile
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
